//--- Makefile
VERILATOR ?= verilator
TOP       := tb_forth_stack
FILELIST  := forth_stack.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# a stopped run or the fail message in the log fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/stack_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cell width is fixed here for every instance
// opcodes outside stack_op_e are rejected by the stack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package stack_pkg;

    localparam int CELL_W  = 32;             // bits per stack cell
    localparam int PADDR_W = 4;              // apb byte address, 4 regs

    typedef logic [CELL_W-1:0]  cell_t;      // one stack cell
    typedef logic [PADDR_W-1:0] paddr_t;     // apb register offset

    // register map, word aligned
    localparam paddr_t REG_PUSH  = 4'h0;     // wo, push pwdata
    localparam paddr_t REG_OP    = 4'h4;     // wo, opcode in pwdata[3:0]
    localparam paddr_t REG_TOS   = 4'h8;     // ro, top of stack
    localparam paddr_t REG_DEPTH = 4'hC;     // ro, cells on stack

    // stack operations, codes 0xA..0xF are illegal
    typedef enum logic [3:0] {
        SS_PUSH = 4'h0,                      // ( -- x )
        SS_DROP = 4'h1,                      // ( x -- )
        SS_DUP  = 4'h2,                      // ( x -- x x )
        SS_SWAP = 4'h3,                      // ( a b -- b a )
        SS_OVER = 4'h4,                      // ( a b -- a b a )
        SS_ADD  = 4'h5,                      // ( a b -- a+b )
        SS_SUB  = 4'h6,                      // ( a b -- a-b )
        SS_AND  = 4'h7,                      // ( a b -- a&b )
        SS_OR   = 4'h8,                      // ( a b -- a|b )
        SS_XOR  = 4'h9                       // ( a b -- a^b )
    } stack_op_e;

    // one command from the bus port to the stack
    typedef struct packed {
        stack_op_e op;                       // what to do
        cell_t     value;                    // push operand only
    } stack_cmd_t;

    // result of one command
    typedef struct packed {
        logic done;                          // single cycle pulse
        logic err;                           // overflow, underflow, bad op
    } stack_rsp_t;

endpackage : stack_pkg

`default_nettype wire

//--- forth_stack.f
common/stack_pkg.sv
logic/tos_alu.sv
stack/stack_ram.sv
stack/data_stack.sv
logic/apb_cmd_port.sv
logic/forth_stack.sv
testbench/forth_stack_chk.sv
testbench/tb_forth_stack.sv

//--- logic/apb_cmd_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writes stall 3 access cycles, reads none
// writes to ro regs become an illegal op
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module apb_cmd_port #(
    parameter  int DEPTH = 16,               // only sizes the depth port
    localparam int DW    = $clog2(DEPTH + 1)
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  stack_pkg::paddr_t     paddr,
    input  stack_pkg::cell_t      pwdata,
    output stack_pkg::cell_t      prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  cmd_valid, // first write access cycle
    output stack_pkg::stack_cmd_t cmd,
    input  stack_pkg::stack_rsp_t rsp,
    input  stack_pkg::cell_t      tos,
    input  logic [DW-1:0]         depth
);

    typedef enum logic {
        PORT_IDLE,                           // no command out
        PORT_BUSY                            // waiting for done
    } port_state_e;

    localparam logic [3:0] OP_BAD = 4'hF;    // stack rejects it

    port_state_e state;
    logic        wr_access;
    logic        rd_access;
    logic        tos_empty;

    assign wr_access = psel && penable && pwrite;
    assign rd_access = psel && penable && !pwrite;
    assign tos_empty = (depth == '0);
    assign cmd_valid = wr_access && (state == PORT_IDLE); // once per write

    always_comb begin
        cmd.value = pwdata;
        case (paddr)
            stack_pkg::REG_PUSH: cmd.op = stack_pkg::SS_PUSH;
            stack_pkg::REG_OP:   cmd.op = stack_pkg::stack_op_e'(pwdata[3:0]);
            default:             cmd.op = stack_pkg::stack_op_e'(OP_BAD);
        endcase
    end

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (paddr)
                stack_pkg::REG_TOS:   if (!tos_empty) prdata = tos; // 0 when empty
                stack_pkg::REG_DEPTH: prdata = stack_pkg::cell_t'(depth);
                default:              prdata = '0;  // wo regs read 0
            endcase
        end
    end

    // reads complete at once, writes on done
    assign pready  = rd_access || (wr_access && state == PORT_BUSY && rsp.done);
    assign pslverr = rd_access ? (paddr == stack_pkg::REG_TOS && tos_empty)
                               : (pready && rsp.err);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= PORT_IDLE;
        end else begin
            case (state)
                PORT_IDLE: if (cmd_valid) state <= PORT_BUSY;
                default:   if (rsp.done) state <= PORT_IDLE;
            endcase
        end
    end

endmodule : apb_cmd_port

`default_nettype wire

//--- logic/forth_stack.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb3 slave, DEPTH >= 2, single issue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module forth_stack #(
    parameter int DEPTH = 16                 // cells incl. TOS
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  stack_pkg::paddr_t paddr,
    input  stack_pkg::cell_t  pwdata,
    output stack_pkg::cell_t  prdata,
    output logic              pready,
    output logic              pslverr
);

    localparam int DW = $clog2(DEPTH + 1);   // depth width
    localparam int AW = $clog2(DEPTH);       // ram address width

    logic                  cmd_valid;
    stack_pkg::stack_cmd_t cmd;
    stack_pkg::stack_rsp_t rsp;
    stack_pkg::cell_t      tos;
    logic [DW-1:0]         depth;
    logic [AW-1:0]         ram_addr;
    logic                  ram_we;
    stack_pkg::cell_t      ram_wdata;
    stack_pkg::cell_t      ram_rdata;

    apb_cmd_port #(.DEPTH(DEPTH)) i_apb_cmd_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .rsp       (rsp),
        .tos       (tos),
        .depth     (depth)
    );

    data_stack #(.DEPTH(DEPTH)) i_data_stack (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .rsp       (rsp),
        .tos       (tos),
        .depth     (depth),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    stack_ram #(.DEPTH(DEPTH)) i_stack_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule : forth_stack

`default_nettype wire

//--- logic/tos_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stack effects only, legality checked by caller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module tos_alu (
    input  stack_pkg::stack_op_e op,         // current operation
    input  stack_pkg::cell_t     tos,        // top of stack
    input  stack_pkg::cell_t     nos,        // next of stack
    input  stack_pkg::cell_t     push_value, // literal for push
    output stack_pkg::cell_t     new_tos,    // tos after op
    output stack_pkg::cell_t     new_nos,    // cell written to ram
    output logic                 sp_up,      // one cell more
    output logic                 sp_down,    // one cell less
    output logic                 nos_write   // rewrite nos in place
);

    always_comb begin
        new_tos   = tos;
        new_nos   = nos;
        sp_up     = 1'b0;
        sp_down   = 1'b0;
        nos_write = 1'b0;
        case (op)
            stack_pkg::SS_PUSH: begin
                new_tos = push_value;
                new_nos = tos;               // old tos spills down
                sp_up   = 1'b1;
            end
            stack_pkg::SS_DROP: begin
                new_tos = nos;
                sp_down = 1'b1;
            end
            stack_pkg::SS_DUP: begin
                new_nos = tos;               // copy below, tos stays
                sp_up   = 1'b1;
            end
            stack_pkg::SS_SWAP: begin
                new_tos   = nos;
                new_nos   = tos;
                nos_write = 1'b1;            // depth unchanged
            end
            stack_pkg::SS_OVER: begin
                new_tos = nos;
                new_nos = tos;
                sp_up   = 1'b1;
            end
            stack_pkg::SS_ADD: begin
                new_tos = nos + tos;         // wraps at CELL_W
                sp_down = 1'b1;
            end
            stack_pkg::SS_SUB: begin
                new_tos = nos - tos;         // forth order, wraps
                sp_down = 1'b1;
            end
            stack_pkg::SS_AND: begin
                new_tos = nos & tos;
                sp_down = 1'b1;
            end
            stack_pkg::SS_OR: begin
                new_tos = nos | tos;
                sp_down = 1'b1;
            end
            stack_pkg::SS_XOR: begin
                new_tos = nos ^ tos;
                sp_down = 1'b1;
            end
            default: new_tos = tos;          // illegal, no effect
        endcase
    end

endmodule : tos_alu

`default_nettype wire

//--- stack/data_stack.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one command in flight, idle -> fetch -> exec
// sp equals depth, NOS sits at ram[sp-2]
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module data_stack #(
    parameter  int DEPTH = 16,               // max cells incl. TOS
    localparam int DW    = $clog2(DEPTH + 1),
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic                  clk,       // clock
    input  logic                  rst_n,     // sync reset
    input  logic                  cmd_valid, // command pulse
    input  stack_pkg::stack_cmd_t cmd,       // op and push value
    output stack_pkg::stack_rsp_t rsp,       // done/err pulse
    output stack_pkg::cell_t      tos,       // cached top of stack
    output logic [DW-1:0]         depth,     // cells on stack
    output logic [AW-1:0]         ram_addr,  // nos / spill address
    output logic                  ram_we,    // spill or rewrite
    output stack_pkg::cell_t      ram_wdata, // cell to ram
    input  stack_pkg::cell_t      ram_rdata  // nos, one cycle late
);

    typedef enum logic [1:0] {
        DS_IDLE,                             // waiting for a command
        DS_FETCH,                            // ram reads nos
        DS_EXEC                              // update tos, sp, ram
    } ds_state_e;

    ds_state_e             state;
    stack_pkg::stack_cmd_t cmd_q;            // held command
    logic [DW-1:0]         sp;               // == depth
    logic [DW-1:0]         need;             // min depth for the op
    logic [DW-1:0]         addr_full;        // untruncated ram address
    logic                  legal;            // known opcode
    logic                  err;              // reject, no state change
    logic                  exec;
    stack_pkg::cell_t      new_tos;
    stack_pkg::cell_t      new_nos;
    logic                  sp_up;
    logic                  sp_down;
    logic                  nos_write;

    tos_alu i_tos_alu (
        .op         (cmd_q.op),
        .tos        (tos),
        .nos        (ram_rdata),             // valid in exec
        .push_value (cmd_q.value),
        .new_tos    (new_tos),
        .new_nos    (new_nos),
        .sp_up      (sp_up),
        .sp_down    (sp_down),
        .nos_write  (nos_write)
    );

    // all legality checks live here
    always_comb begin
        legal = 1'b1;
        need  = '0;
        case (cmd_q.op)
            stack_pkg::SS_PUSH: need = '0;
            stack_pkg::SS_DROP,
            stack_pkg::SS_DUP:  need = DW'(1);
            stack_pkg::SS_SWAP, stack_pkg::SS_OVER,
            stack_pkg::SS_ADD,  stack_pkg::SS_SUB,
            stack_pkg::SS_AND,  stack_pkg::SS_OR,
            stack_pkg::SS_XOR:  need = DW'(2);
            default:            legal = 1'b0;   // 0xA..0xF
        endcase
    end

    assign err  = !legal || (sp < need) || (sp_up && sp == DW'(DEPTH)); // overflow on full
    assign exec = (state == DS_EXEC);

    assign rsp.done = exec;
    assign rsp.err  = exec && err;

    // fetch reads nos, exec on a push spills old tos above it
    assign addr_full = (exec && sp_up) ? sp - DW'(1) : sp - DW'(2);
    assign ram_addr  = addr_full[AW-1:0];
    assign ram_we    = exec && !err && ((sp_up && sp != '0) || nos_write); // no spill when empty
    assign ram_wdata = new_nos;
    assign depth     = sp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= DS_IDLE;
            sp    <= '0;
            tos   <= '0;
        end else begin
            case (state)
                DS_IDLE:  if (cmd_valid) state <= DS_FETCH;
                DS_FETCH: state <= DS_EXEC;
                default:  state <= DS_IDLE;  // exec is one cycle
            endcase
            if (exec && !err) begin
                tos <= new_tos;
                if (sp_up) begin
                    sp <= sp + DW'(1);
                end else if (sp_down) begin
                    sp <= sp - DW'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == DS_IDLE && cmd_valid) begin
            cmd_q <= cmd;                    // payload, held to exec
        end
    end

endmodule : data_stack

`default_nettype wire

//--- stack/stack_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DEPTH-1 cells, TOS lives outside, DEPTH >= 2
// read data valid one cycle after addr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module stack_ram #(
    parameter  int DEPTH = 16,               // stack depth incl. TOS
    localparam int AW    = $clog2(DEPTH)     // enough for DEPTH-1 entries
) (
    input  logic             clk,            // clock
    input  logic [AW-1:0]    addr,           // shared rd/wr address
    input  logic             we,             // write enable
    input  stack_pkg::cell_t wdata,          // cell to store
    output stack_pkg::cell_t rdata           // registered read
);

    localparam int ENTRIES = DEPTH - 1;      // cells below the TOS

    stack_pkg::cell_t mem [ENTRIES];         // block ram stand-in

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;              // one write ...
        end
        rdata <= mem[addr];                  // ... or one read, read-first
    end

endmodule : stack_ram

`default_nettype wire

//--- testbench/forth_stack_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound into forth_stack, sees the internal depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module forth_stack_chk #(
    parameter  int DEPTH = 16,               // must match the bound instance
    localparam int DW    = $clog2(DEPTH + 1)
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          psel,
    input  logic          penable,
    input  logic          pready,
    input  logic          pslverr,
    input  logic [DW-1:0] depth              // cells on stack
);

    ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> (psel && penable))
        else $error("pready high outside an access cycle");

    err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> pready)
        else $error("pslverr high without pready");

    depth_bound: assert property (@(posedge clk) disable iff (!rst_n)
        depth <= DW'(DEPTH))
        else $error("stack depth above DEPTH");

    // no completion right out of reset
    ready_after_reset: assert property (@(posedge clk) !rst_n |=> !pready)
        else $error("pready high in the cycle after reset");

endmodule : forth_stack_chk

bind forth_stack forth_stack_chk #(.DEPTH(DEPTH)) i_forth_stack_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .depth   (depth)
);

`default_nettype wire

//--- testbench/tb_forth_stack.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests on DEPTH 16 with a queue model of the stack
// every test starts and ends with an empty stack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module tb_forth_stack;

    localparam int DEPTH       = 16;
    localparam int CLK_NS      = 4;
    localparam int XFER_TOTAL  = 250;                    // transfers over all tests rounded up
    localparam int WATCHDOG_NS = 20 * XFER_TOTAL * 3 * CLK_NS;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    stack_pkg::paddr_t paddr;
    stack_pkg::cell_t  pwdata;
    stack_pkg::cell_t  prdata;
    logic              pready;
    logic              pslverr;

    stack_pkg::cell_t  model [$];                        // back is the TOS
    int                errors;
    int                checks;

    forth_stack #(.DEPTH(DEPTH)) i_forth_stack (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // one apb transfer sampled at negedge
    task automatic apb_xfer(input logic wr, input stack_pkg::paddr_t addr,
                            input stack_pkg::cell_t data, output stack_pkg::cell_t rdata,
                            output logic err, output int cycles);
        logic done;
        done   = 1'b0;
        cycles = 0;
        @(posedge clk);
        psel    <= 1'b1;                                 // setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;                                 // access phase
        while (!done) begin
            @(negedge clk);
            cycles++;
            done  = pready;
            rdata = prdata;
            err   = pslverr;
            @(posedge clk);
        end
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input stack_pkg::paddr_t addr, input stack_pkg::cell_t data,
                             output logic err, output int cycles);
        stack_pkg::cell_t ignored;
        apb_xfer(1'b1, addr, data, ignored, err, cycles);
    endtask

    task automatic apb_read(input stack_pkg::paddr_t addr, output stack_pkg::cell_t rdata,
                            output logic err, output int cycles);
        apb_xfer(1'b0, addr, '0, rdata, err, cycles);
    endtask

    task automatic check_value(input string what, input stack_pkg::cell_t got,
                               input stack_pkg::cell_t exp);
        checks++;
        assert (got === exp) else begin
            $display("error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    // applies forth semantics to the queue and returns the expected reject flag
    function automatic logic model_step(input logic [3:0] op, input stack_pkg::cell_t val);
        int               n;
        stack_pkg::cell_t a;
        stack_pkg::cell_t b;
        stack_pkg::cell_t r;
        n = model.size();
        case (op)
            stack_pkg::SS_PUSH: begin
                if (n >= DEPTH) return 1'b1;             // overflow
                model.push_back(val);
            end
            stack_pkg::SS_DROP: begin
                if (n < 1) return 1'b1;
                void'(model.pop_back());
            end
            stack_pkg::SS_DUP: begin
                if (n < 1 || n >= DEPTH) return 1'b1;
                model.push_back(model[n-1]);
            end
            stack_pkg::SS_SWAP: begin
                if (n < 2) return 1'b1;
                a          = model[n-2];
                model[n-2] = model[n-1];
                model[n-1] = a;
            end
            stack_pkg::SS_OVER: begin
                if (n < 2 || n >= DEPTH) return 1'b1;
                model.push_back(model[n-2]);
            end
            stack_pkg::SS_ADD, stack_pkg::SS_SUB, stack_pkg::SS_AND,
            stack_pkg::SS_OR, stack_pkg::SS_XOR: begin
                if (n < 2) return 1'b1;
                b = model.pop_back();                    // tos
                a = model.pop_back();                    // nos
                case (op)
                    stack_pkg::SS_ADD: r = a + b;
                    stack_pkg::SS_SUB: r = a - b;        // nos minus tos
                    stack_pkg::SS_AND: r = a & b;
                    stack_pkg::SS_OR:  r = a | b;
                    default:           r = a ^ b;
                endcase
                model.push_back(r);
            end
            default: return 1'b1;                        // unused opcode
        endcase
        return 1'b0;
    endfunction

    // push goes to REG_PUSH and all else to REG_OP with junk above the opcode
    task automatic run_cmd(input logic [3:0] op, input stack_pkg::cell_t val);
        logic             exp_err;
        logic             err;
        int               cycles;
        stack_pkg::cell_t rnd;
        rnd     = $urandom();
        exp_err = model_step(op, val);
        if (op == stack_pkg::SS_PUSH) begin
            apb_write(stack_pkg::REG_PUSH, val, err, cycles);
        end else begin
            apb_write(stack_pkg::REG_OP, {rnd[31:4], op}, err, cycles);
        end
        check_value("write pslverr", stack_pkg::cell_t'(err), stack_pkg::cell_t'(exp_err));
        check_value("write access cycles", stack_pkg::cell_t'(cycles), 3);
    endtask

    task automatic check_state();
        stack_pkg::cell_t rdata;
        logic             err;
        int               cycles;
        logic             empty;
        empty = (model.size() == 0);
        apb_read(stack_pkg::REG_DEPTH, rdata, err, cycles);
        check_value("depth", rdata, stack_pkg::cell_t'(model.size()));
        check_value("depth pslverr", stack_pkg::cell_t'(err), 0);
        check_value("read access cycles", stack_pkg::cell_t'(cycles), 1);
        apb_read(stack_pkg::REG_TOS, rdata, err, cycles);
        check_value("tos", rdata, empty ? '0 : model[$]); // empty reads 0
        check_value("tos pslverr", stack_pkg::cell_t'(err), stack_pkg::cell_t'(empty));
        check_value("read access cycles", stack_pkg::cell_t'(cycles), 1);
    endtask

    task automatic log_result(input string name, input int errs_before);
        $display("%-16s %s, %0d errors", name, (errors == errs_before) ? "ok" : "failed",
                 errors - errs_before);
    endtask

    task automatic lifo_order();
        int e0;
        e0 = errors;
        repeat (8) begin
            run_cmd(stack_pkg::SS_PUSH, $urandom());
            check_state();
        end
        repeat (8) begin
            run_cmd(stack_pkg::SS_DROP, '0);
            check_state();
        end
        log_result("lifo order", e0);
    endtask

    task automatic stack_shuffles();
        int e0;
        e0 = errors;
        run_cmd(stack_pkg::SS_PUSH, 32'h1111_1111);
        run_cmd(stack_pkg::SS_PUSH, 32'h2222_2222);
        run_cmd(stack_pkg::SS_PUSH, 32'h3333_3333);
        check_state();
        run_cmd(stack_pkg::SS_SWAP, '0);                 // 11 33 22
        check_state();
        run_cmd(stack_pkg::SS_OVER, '0);                 // 11 33 22 33
        check_state();
        run_cmd(stack_pkg::SS_DUP, '0);                  // 11 33 22 33 33
        check_state();
        repeat (5) begin
            run_cmd(stack_pkg::SS_DROP, '0);             // lower cells come up
            check_state();
        end
        log_result("stack shuffles", e0);
    endtask

    task automatic arithmetic_ops();
        logic [3:0]       ops [5] = '{stack_pkg::SS_ADD, stack_pkg::SS_SUB, stack_pkg::SS_AND,
                                      stack_pkg::SS_OR, stack_pkg::SS_XOR};
        stack_pkg::cell_t a;
        stack_pkg::cell_t b;
        int               e0;
        e0 = errors;
        foreach (ops[i]) begin
            for (int k = 0; k < 2; k++) begin
                a = (k == 0) ? $urandom() : 32'h0000_0001;
                b = (k == 0) ? $urandom() : 32'hFFFF_FFFF; // wraps add and sub
                run_cmd(stack_pkg::SS_PUSH, a);
                run_cmd(stack_pkg::SS_PUSH, b);
                run_cmd(ops[i], '0);
                check_state();
                run_cmd(stack_pkg::SS_DROP, '0);
            end
        end
        log_result("arithmetic", e0);
    endtask

    task automatic overflow_reject();
        int e0;
        e0 = errors;
        repeat (DEPTH) run_cmd(stack_pkg::SS_PUSH, $urandom());
        check_state();
        run_cmd(stack_pkg::SS_PUSH, $urandom());         // one too many
        check_state();
        run_cmd(stack_pkg::SS_OVER, '0);
        check_state();
        repeat (DEPTH) begin
            run_cmd(stack_pkg::SS_DROP, '0);             // whole ram read back
            check_state();
        end
        log_result("overflow", e0);
    endtask

    task automatic underflow_reject();
        logic [3:0] empty_ops [4] = '{stack_pkg::SS_DROP, stack_pkg::SS_SWAP,
                                      stack_pkg::SS_ADD, 4'hF};
        logic [3:0] one_ops [4]   = '{stack_pkg::SS_SWAP, stack_pkg::SS_ADD,
                                      stack_pkg::SS_OVER, 4'hF};
        int         e0;
        e0 = errors;
        check_state();                                   // tos read at depth 0
        foreach (empty_ops[i]) begin
            run_cmd(empty_ops[i], '0);
            check_state();
        end
        run_cmd(stack_pkg::SS_PUSH, $urandom());
        check_state();
        foreach (one_ops[i]) begin
            run_cmd(one_ops[i], '0);
            check_state();
        end
        run_cmd(stack_pkg::SS_DROP, '0);
        check_state();
        log_result("underflow", e0);
    endtask

    task automatic wait_states();
        stack_pkg::cell_t rdata;
        logic             err;
        int               cycles;
        int               e0;
        e0 = errors;
        run_cmd(stack_pkg::SS_PUSH, $urandom());         // 3 cycles checked inside
        check_state();
        apb_read(stack_pkg::REG_PUSH, rdata, err, cycles); // write-only reg
        check_value("read access cycles", stack_pkg::cell_t'(cycles), 1);
        check_value("read pslverr", stack_pkg::cell_t'(err), 0);
        run_cmd(4'hE, '0);                               // rejected in 3 cycles too
        run_cmd(stack_pkg::SS_DROP, '0);
        check_state();
        log_result("wait states", e0);
    endtask

    initial begin
        void'($urandom(96498));
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        errors  = 0;
        checks  = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        lifo_order();
        stack_shuffles();
        arithmetic_ops();
        overflow_reject();
        underflow_reject();
        wait_states();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule : tb_forth_stack

`default_nettype wire
